// File: common/daq_pkg.sv
`default_nettype none

package daq_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------
  localparam int bus_width  = 16;
  localparam int addr_width = 19;
  localparam int time_width = 32;

  typedef logic [bus_width-1:0]  bus_word_t;
  // only the low byte is decoded
  typedef logic [addr_width-1:0] bus_addr_t;
  typedef logic [bus_width-1:0]  sample_t;
  typedef logic [time_width-1:0] time_t;

  // --------------------------------------------------------------------------
  // host register map
  // --------------------------------------------------------------------------
  localparam logic [7:0] reg_status      = 8'd0;
  localparam logic [7:0] reg_cmd_w1      = 8'd1;
  localparam logic [7:0] reg_cmd_w2      = 8'd2;
  localparam logic [7:0] reg_cmd_w3      = 8'd3;
  localparam logic [7:0] reg_cmd_w4      = 8'd4;
  // write to w5 also queues the command
  localparam logic [7:0] reg_cmd_w5      = 8'd5;
  localparam logic [7:0] reg_next_sample = 8'd6;
  localparam logic [7:0] reg_time_reset  = 8'd7;
  localparam logic [7:0] reg_time_run    = 8'd8;
  localparam logic [7:0] reg_time_lo     = 8'd9;
  localparam logic [7:0] reg_time_hi     = 8'd10;

  // command record, word 1 in the low bits
  typedef struct packed {
    bus_word_t mask;
    bus_word_t gap;
    bus_word_t step;
    bus_word_t start;
    bus_word_t count;
  } cmd_t;

endpackage

`default_nettype wire

// File: hw/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [15:0],
  parameter int  depth     = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t wr_data,
  input  logic     push,
  output payload_t rd_data,
  input  logic     pop,
  output logic     full,
  output logic     almost_full,
  output logic     empty,
  output logic     almost_empty
);

  // depth is a power of two so pointers wrap on their own
  localparam int aw = $clog2(depth);
  localparam logic [aw:0] full_lvl = (aw + 1)'(depth);
  localparam logic [aw:0] last_lvl = (aw + 1)'(depth - 1);

  payload_t      mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   used;
  logic          do_push;
  logic          do_pop;

  // illegal strobes are ignored
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign full         = (used == full_lvl);
  assign almost_full  = (used == last_lvl);
  assign empty        = (used == '0);
  assign almost_empty = (used == 1);

  // head is shown combinationally
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // --------------------------------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   used <= used + 1'b1;
        2'b01:   used <= used - 1'b1;
        default: used <= used;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/sample_engine.sv
`default_nettype none

module sample_engine (
  input  logic             clk,
  input  logic             rst,
  // command fifo head
  input  daq_pkg::cmd_t    cmd_data,
  input  logic             cmd_empty,
  output logic             cmd_pop,
  // sample fifo write side
  output daq_pkg::sample_t smp_data,
  output logic             smp_push,
  input  logic             smp_full
);
  import daq_pkg::*;

  typedef enum logic {idle, emit} state_t;

  state_t    state;
  // samples still to send
  bus_word_t remain_q;
  // cycles left before the next sample
  bus_word_t gap_cnt_q;
  sample_t   value_q;
  bus_word_t step_q;
  bus_word_t gap_q;
  bus_word_t mask_q;

  assign cmd_pop  = (state == idle) && !cmd_empty;
  // full flag is the only flow control
  assign smp_push = (state == emit) && (gap_cnt_q == '0) && !smp_full;
  assign smp_data = value_q ^ mask_q;

  // --------------------------------------------------------------------------
  // sequencing
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      remain_q  <= '0;
      gap_cnt_q <= '0;
    end else begin
      case (state)
        idle: begin
          if (cmd_pop) begin
            remain_q  <= cmd_data.count;
            gap_cnt_q <= '0;
            // zero count: popped, nothing sent
            if (cmd_data.count != '0) begin
              state <= emit;
            end
          end
        end
        emit: begin
          if (gap_cnt_q != '0) begin
            gap_cnt_q <= gap_cnt_q - 1'b1;
          end else if (smp_push) begin
            remain_q  <= remain_q - 1'b1;
            // period of max(1, gap) cycles
            gap_cnt_q <= (gap_q > 16'd1) ? gap_q - 16'd1 : '0;
            if (remain_q == 16'd1) begin
              state <= idle;
            end
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // ramp value, mask applied on output
  always_ff @(posedge clk) begin
    if (cmd_pop) begin
      value_q <= cmd_data.start;
      step_q  <= cmd_data.step;
      gap_q   <= cmd_data.gap;
      mask_q  <= cmd_data.mask;
    end else if (smp_push) begin
      value_q <= value_q + step_q;
    end
  end

endmodule

`default_nettype wire

// File: hw/ebi/ebi_bridge.sv
`default_nettype none

module ebi_bridge (
  input  logic               clk,
  input  logic               rst,
  // host bus
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  daq_pkg::bus_addr_t addr,
  input  daq_pkg::bus_word_t data_in,
  output daq_pkg::bus_word_t data_out,
  output logic               irq,
  // command fifo write side
  output daq_pkg::cmd_t      cmd_data,
  output logic               cmd_push,
  input  logic               cmd_full,
  input  logic               cmd_almost_full,
  input  logic               cmd_almost_empty,
  input  logic               cmd_empty,
  // sample fifo read side
  input  daq_pkg::sample_t   smp_data,
  output logic               smp_pop,
  input  logic               smp_full,
  input  logic               smp_almost_full,
  input  logic               smp_almost_empty,
  input  logic               smp_empty,
  output daq_pkg::time_t     global_time
);
  import daq_pkg::*;

  // status right after reset: both fifos empty
  localparam bus_word_t status_rst = 16'h1200;

  typedef enum logic [1:0] {idle, fetch, sample_wait, sample_load} state_t;

  state_t     state;
  state_t     next_state;
  logic [7:0] reg_sel;
  logic [7:0] wr_sel_q;
  logic       rd_d;
  logic       rd_dd;
  logic       wr_d;
  logic       wr_dd;
  logic       rd_done;
  logic       wr_done;
  logic       push_q;
  logic       capture_word;
  logic       reset_time;
  logic       run_time;
  logic       running;
  cmd_t       cmd_q;
  sample_t    hold_q;
  bus_word_t  status_q;
  bus_word_t  status_seen_q;
  bus_word_t  time_hi_q;
  time_t      time_q;

  assign reg_sel = addr[7:0];

  // --------------------------------------------------------------------------
  // falling edge detect of qualified rd and wr
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_d  <= 1'b0;
      rd_dd <= 1'b0;
      wr_d  <= 1'b0;
      wr_dd <= 1'b0;
    end else begin
      rd_d  <= rd & cs;
      rd_dd <= rd_d;
      wr_d  <= wr & cs;
      wr_dd <= wr_d;
    end
  end

  // high for one cycle once the strobe is seen low
  assign rd_done = rd_dd & ~rd_d;
  assign wr_done = wr_dd & ~wr_d;

  // --------------------------------------------------------------------------
  // control fsm
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state   = state;
    capture_word = 1'b0;
    reset_time   = 1'b0;
    run_time     = 1'b0;
    smp_pop      = 1'b0;
    case (state)
      idle: begin
        next_state = fetch;
      end
      fetch: begin
        if (cs && wr) begin
          capture_word = 1'b1;
          reset_time   = (reg_sel == reg_time_reset);
          run_time     = (reg_sel == reg_time_run);
        end else if (cs && rd && reg_sel == reg_next_sample) begin
          next_state = sample_wait;
        end
      end
      // host still holds the current sample
      sample_wait: begin
        if (rd_done) begin
          next_state = sample_load;
        end
      end
      // prefetch for the next read
      sample_load: begin
        smp_pop    = ~smp_empty;
        next_state = fetch;
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // command capture and push
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (capture_word) begin
      case (reg_sel)
        reg_cmd_w1: cmd_q.count <= data_in;
        reg_cmd_w2: cmd_q.start <= data_in;
        reg_cmd_w3: cmd_q.step  <= data_in;
        reg_cmd_w4: cmd_q.gap   <= data_in;
        reg_cmd_w5: cmd_q.mask  <= data_in;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_sel_q <= reg_status;
      push_q   <= 1'b0;
    end else begin
      // remember which register the pending write hit
      if (capture_word) begin
        wr_sel_q <= reg_sel;
      end
      push_q <= wr_done && (wr_sel_q == reg_cmd_w5);
    end
  end

  assign cmd_data = cmd_q;
  // command dropped when the fifo is full
  assign cmd_push = push_q & ~cmd_full;

  // --------------------------------------------------------------------------
  // sample holding, status and irq
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_q        <= 16'hdead;
      status_q      <= status_rst;
      status_seen_q <= status_rst;
      irq           <= 1'b0;
    end else begin
      if (state == sample_load && !smp_empty) begin
        hold_q <= smp_data;
      end
      status_q <= {cmd_almost_full, cmd_full, cmd_almost_empty, cmd_empty,
                   smp_almost_full, smp_full, smp_empty, smp_almost_empty, 8'h00};
      // copy seen by the host
      if (cs && rd && reg_sel == reg_status) begin
        status_seen_q <= status_q;
      end
      irq <= (status_q != status_seen_q);
    end
  end

  // read mux, valid from the second cycle of a read
  always_ff @(posedge clk) begin
    if (cs && rd) begin
      case (reg_sel)
        reg_status:      data_out <= status_q;
        reg_next_sample: data_out <= hold_q;
        reg_time_lo:     data_out <= time_q[15:0];
        reg_time_hi:     data_out <= time_hi_q;
        default:         data_out <= '0;
      endcase
      // high half frozen with the low read
      if (reg_sel == reg_time_lo) begin
        time_hi_q <= time_q[31:16];
      end
    end
  end

  // --------------------------------------------------------------------------
  // acquisition timer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      time_q  <= '0;
      running <= 1'b0;
    end else if (reset_time) begin
      // a reset also stops it
      time_q  <= '0;
      running <= 1'b0;
    end else begin
      if (running) begin
        time_q <= time_q + 1'b1;
      end
      if (run_time) begin
        running <= 1'b1;
      end
    end
  end

  assign global_time = time_q;

endmodule

`default_nettype wire

// File: hw/daq_top.sv
`default_nettype none

module daq_top #(
  parameter int cmd_depth    = 4,
  parameter int sample_depth = 16
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  daq_pkg::bus_addr_t addr,
  input  daq_pkg::bus_word_t data_in,
  output daq_pkg::bus_word_t data_out,
  output logic               irq,
  output daq_pkg::time_t     global_time
);
  import daq_pkg::*;

  // --------------------------------------------------------------------------
  // command path
  // --------------------------------------------------------------------------
  cmd_t    cmd_wr_data;
  cmd_t    cmd_rd_data;
  logic    cmd_push;
  logic    cmd_pop;
  logic    cmd_full;
  logic    cmd_almost_full;
  logic    cmd_empty;
  logic    cmd_almost_empty;

  // sample path
  sample_t smp_wr_data;
  sample_t smp_rd_data;
  logic    smp_push;
  logic    smp_pop;
  logic    smp_full;
  logic    smp_almost_full;
  logic    smp_empty;
  logic    smp_almost_empty;

  ebi_bridge u_ebi_bridge (
    .clk              (clk),
    .rst              (rst),
    .cs               (cs),
    .rd               (rd),
    .wr               (wr),
    .addr             (addr),
    .data_in          (data_in),
    .data_out         (data_out),
    .irq              (irq),
    .cmd_data         (cmd_wr_data),
    .cmd_push         (cmd_push),
    .cmd_full         (cmd_full),
    .cmd_almost_full  (cmd_almost_full),
    .cmd_almost_empty (cmd_almost_empty),
    .cmd_empty        (cmd_empty),
    .smp_data         (smp_rd_data),
    .smp_pop          (smp_pop),
    .smp_full         (smp_full),
    .smp_almost_full  (smp_almost_full),
    .smp_almost_empty (smp_almost_empty),
    .smp_empty        (smp_empty),
    .global_time      (global_time)
  );

  sync_fifo #(
    .payload_t (cmd_t),
    .depth     (cmd_depth)
  ) u_cmd_fifo (
    .clk          (clk),
    .rst          (rst),
    .wr_data      (cmd_wr_data),
    .push         (cmd_push),
    .rd_data      (cmd_rd_data),
    .pop          (cmd_pop),
    .full         (cmd_full),
    .almost_full  (cmd_almost_full),
    .empty        (cmd_empty),
    .almost_empty (cmd_almost_empty)
  );

  // engine latches the head on its own pop
  sample_engine u_sample_engine (
    .clk       (clk),
    .rst       (rst),
    .cmd_data  (cmd_rd_data),
    .cmd_empty (cmd_empty),
    .cmd_pop   (cmd_pop),
    .smp_data  (smp_wr_data),
    .smp_push  (smp_push),
    .smp_full  (smp_full)
  );

  sync_fifo #(
    .payload_t (sample_t),
    .depth     (sample_depth)
  ) u_smp_fifo (
    .clk          (clk),
    .rst          (rst),
    .wr_data      (smp_wr_data),
    .push         (smp_push),
    .rd_data      (smp_rd_data),
    .pop          (smp_pop),
    .full         (smp_full),
    .almost_full  (smp_almost_full),
    .empty        (smp_empty),
    .almost_empty (smp_almost_empty)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held over the first 10 rising edges
  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: tests/daq_assert.sv
`default_nettype none

module daq_assert (
  input logic               clk,
  input logic               rst,
  input logic               cs,
  input logic               rd,
  input logic               wr,
  input daq_pkg::bus_addr_t addr,
  input logic               cmd_push,
  input logic               cmd_full,
  input logic               smp_pop
);
  timeunit 1ns;
  timeprecision 100ps;

  import daq_pkg::*;

  // --------------------------------------------------------------------------
  // bridge strobe rules
  // --------------------------------------------------------------------------

  // no fifo strobes in the cycle after a reset cycle
  quiet_after_reset: assert property (
    @(posedge clk) rst |=> !cmd_push && !smp_pop
  ) else $error("cmd_push or smp_pop high in the cycle after reset");

  // push only for a finished w5 write, never into a full fifo
  push_after_cmd_write: assert property (
    @(posedge clk) disable iff (rst)
      cmd_push |-> !cmd_full && $past(cs && wr && addr[7:0] == reg_cmd_w5, 3) &&
                   !$past(cs && wr, 2)
  ) else $error("cmd_push without a finished w5 write or while cmd_full is high");

  // pop lands two cycles after rd with cs was first seen low
  pop_after_read: assert property (
    @(posedge clk) disable iff (rst)
      smp_pop |-> $past(cs && rd, 3) && !$past(cs && rd, 2)
  ) else $error("smp_pop without a falling rd two cycles earlier");

endmodule

`default_nettype wire

// File: tests/daq_tb.sv
`default_nettype none

module daq_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import daq_pkg::*;

  localparam int cmd_depth    = 4;
  localparam int sample_depth = 16;
  localparam int n_cmds       = 8;
  localparam int max_count    = 6;
  // tests 2 and 3: five writes and a poll per command, poll and read per sample
  localparam int planned_ops  = 2 * n_cmds * (6 + 2 * max_count) + 64;
  localparam int cycle_limit  = planned_ops * 10 + 2000;

  // status word bits
  localparam bus_word_t cmd_full_m  = 16'h4000;
  localparam bus_word_t cmd_empty_m = 16'h1000;
  localparam bus_word_t smp_af_m    = 16'h0800;
  localparam bus_word_t smp_full_m  = 16'h0400;
  localparam bus_word_t smp_empty_m = 16'h0200;
  localparam bus_word_t smp_ae_m    = 16'h0100;

  logic      clk;
  logic      rst;
  logic      cs;
  logic      rd;
  logic      wr;
  bus_addr_t addr;
  bus_word_t data_in;
  bus_word_t data_out;
  logic      irq;
  time_t     global_time;

  integer    seed;
  int        errors;
  int        checks;
  int        cycles = 0;
  // samples not yet in the bridge holding register, oldest first
  sample_t   exp_q[$];
  sample_t   hold_exp;

  tb_clock u_tb_clock (
    .clk (clk),
    .rst (rst)
  );

  daq_top #(
    .cmd_depth    (cmd_depth),
    .sample_depth (sample_depth)
  ) u_daq_top (
    .clk         (clk),
    .rst         (rst),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .addr        (addr),
    .data_in     (data_in),
    .data_out    (data_out),
    .irq         (irq),
    .global_time (global_time)
  );

  bind ebi_bridge daq_assert u_daq_assert (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .rd       (rd),
    .wr       (wr),
    .addr     (addr),
    .cmd_push (cmd_push),
    .cmd_full (cmd_full),
    .smp_pop  (smp_pop)
  );

  // --------------------------------------------------------------------------
  // checking and host bus access
  // --------------------------------------------------------------------------
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // strobe held 3 cycles, then 3 idle cycles
  task automatic bus_write(input logic [7:0] reg_addr, input bus_word_t value);
    @(posedge clk);
    #1;
    cs      = 1'b1;
    wr      = 1'b1;
    addr    = bus_addr_t'(reg_addr);
    data_in = value;
    repeat (3) @(posedge clk);
    #1;
    cs = 1'b0;
    wr = 1'b0;
    repeat (3) @(posedge clk);
    #1;
  endtask

  // data_out sampled just after the last edge with rd high
  task automatic bus_read(input logic [7:0] reg_addr, output bus_word_t value);
    @(posedge clk);
    #1;
    cs   = 1'b1;
    rd   = 1'b1;
    addr = bus_addr_t'(reg_addr);
    repeat (3) @(posedge clk);
    #1;
    value = data_out;
    cs    = 1'b0;
    rd    = 1'b0;
    repeat (3) @(posedge clk);
    #1;
  endtask

  // poll status until the masked bits match
  task automatic wait_status(input bus_word_t mask, input bus_word_t value);
    bus_word_t st;
    bus_read(reg_status, st);
    while ((st & mask) != value) begin
      bus_read(reg_status, st);
    end
  endtask

  // status with an idle command fifo and n samples stored
  function automatic bus_word_t idle_status(input int n);
    bus_word_t st;
    st = cmd_empty_m;
    st |= (n == 0) ? smp_empty_m : 16'h0000;
    st |= (n == 1) ? smp_ae_m : 16'h0000;
    st |= (n == sample_depth - 1) ? smp_af_m : 16'h0000;
    st |= (n == sample_depth) ? smp_full_m : 16'h0000;
    return st;
  endfunction

  // --------------------------------------------------------------------------
  // model
  // --------------------------------------------------------------------------

  // random command, its ramp queued by (start + k*step) ^ mask
  task automatic push_command(output int count_out);
    bus_word_t count;
    bus_word_t start;
    bus_word_t step;
    bus_word_t gap;
    bus_word_t mask;
    count = 16'(($unsigned($random(seed)) % max_count) + 1);
    start = 16'($random(seed));
    step  = 16'($random(seed));
    gap   = 16'($unsigned($random(seed)) % 4);
    mask  = 16'($random(seed));
    for (int k = 0; k < int'(count); k++) begin
      exp_q.push_back((start + bus_word_t'(k) * step) ^ mask);
    end
    bus_write(reg_cmd_w1, count);
    bus_write(reg_cmd_w2, start);
    bus_write(reg_cmd_w3, step);
    bus_write(reg_cmd_w4, gap);
    bus_write(reg_cmd_w5, mask);
    count_out = int'(count);
  endtask

  // read returns the held sample; pop only when samples are pending
  task automatic fetch_sample();
    bus_word_t got;
    if (exp_q.size() > 0) begin
      // fifo cannot drain behind our back, only this read pops
      wait_status(smp_empty_m, 16'h0000);
    end
    bus_read(reg_next_sample, got);
    check_eq(32'(got), 32'(hold_exp), "sample read");
    if (exp_q.size() > 0) begin
      hold_exp = exp_q.pop_front();
    end
  endtask

  task automatic drain_samples();
    while (exp_q.size() > 0) begin
      fetch_sample();
    end
    // last one still sits in the holding register
    fetch_sample();
  endtask

  task automatic timer_value(output time_t t);
    bus_word_t lo;
    bus_word_t hi;
    // low read freezes the high half
    bus_read(reg_time_lo, lo);
    bus_read(reg_time_hi, hi);
    t = {hi, lo};
  endtask

  task automatic wait_irq(output logic seen);
    int n;
    seen = irq;
    n    = 0;
    while (!seen && n < 100) begin
      @(posedge clk);
      #1;
      seen = irq;
      n++;
    end
  endtask

  task automatic report_test(input int num, input string name, input int start_errors);
    if (errors == start_errors) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - start_errors);
    end
  endtask

  // --------------------------------------------------------------------------
  // run limit
  // --------------------------------------------------------------------------
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == cycle_limit) begin
      $display("run hung: tests not finished after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  initial begin
    int        base;
    int        cnt;
    bus_word_t st;
    time_t     t1;
    time_t     t2;
    logic      seen;
    seed     = 19;
    errors   = 0;
    checks   = 0;
    hold_exp = 16'hdead;
    cs       = 1'b0;
    rd       = 1'b0;
    wr       = 1'b0;
    addr     = '0;
    data_in  = '0;
    wait (rst == 1'b0);
    @(posedge clk);
    #1;

    // reset state
    base = errors;
    check_eq(32'(irq), 32'd0, "irq after reset");
    bus_read(reg_status, st);
    check_eq(32'(st), 32'(idle_status(0)), "status after reset");
    fetch_sample();
    report_test(1, "reset state", base);

    // one command at a time, drained before the next
    base = errors;
    for (int i = 0; i < n_cmds; i++) begin
      wait_status(cmd_full_m, 16'h0000);
      push_command(cnt);
      while (exp_q.size() > 0) begin
        fetch_sample();
      end
    end
    fetch_sample();
    report_test(2, "random commands", base);

    // back-pressure, reads held off until the sample fifo is full
    base = errors;
    for (int i = 0; i < n_cmds; i++) begin
      bus_read(reg_status, st);
      while ((st & cmd_full_m) != 16'h0000) begin
        // engine stalled on a full sample fifo, make room
        if ((st & smp_full_m) != 16'h0000) begin
          fetch_sample();
        end
        bus_read(reg_status, st);
      end
      push_command(cnt);
    end
    if (exp_q.size() >= sample_depth) begin
      wait_status(smp_full_m, smp_full_m);
    end else begin
      wait_status(cmd_empty_m, cmd_empty_m);
    end
    drain_samples();
    report_test(3, "back-pressure", base);

    // timer
    base = errors;
    bus_write(reg_time_reset, 16'h0000);
    timer_value(t1);
    check_eq(t1, 32'd0, "timer after reset write");
    bus_write(reg_time_run, 16'h0000);
    timer_value(t1);
    timer_value(t2);
    check_eq(32'(t2 > t1), 32'd1, "timer strictly increasing");
    // live counter already past the last coherent read
    check_eq(32'(global_time > t2), 32'd1, "global_time running");
    bus_write(reg_time_reset, 16'h0000);
    timer_value(t1);
    check_eq(t1, 32'd0, "timer after second reset write");
    timer_value(t2);
    check_eq(t2, 32'd0, "timer stays stopped");
    check_eq(global_time, 32'd0, "global_time stopped");
    report_test(4, "timer", base);

    // irq follows status changes
    base = errors;
    bus_read(reg_status, st);
    check_eq(32'(irq), 32'd0, "irq after status read");
    push_command(cnt);
    wait_irq(seen);
    check_eq(32'(seen), 32'd1, "irq raised by new samples");
    // status settles once all samples are stored
    wait_status(16'hff00, idle_status(cnt));
    check_eq(32'(irq), 32'd0, "irq cleared by stable status read");
    drain_samples();
    report_test(5, "irq", base);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
common/daq_pkg.sv
hw/sync_fifo.sv
hw/sample_engine.sv
hw/ebi/ebi_bridge.sv
hw/daq_top.sv
tests/tb_clock.sv
tests/daq_assert.sv
tests/daq_tb.sv

// File: Makefile
# Verilator build and run of the DAQ bridge testbench

VERILATOR ?= verilator
TOP       ?= daq_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
